//--- rtl/ex_pkg.sv
package ex_pkg;

    // ############################################################
    // Widths
    // ############################################################
    localparam int data_w   = 32;
    localparam int strb_w   = data_w / 8;
    localparam int ld_kinds = 6;   // ld.b, ld.bu, ld.h, ld.hu, ld.w, ll.w
    localparam int st_kinds = 4;   // st.b, st.h, st.w, sc.w

    typedef enum logic [4:0] {
        op_or, op_nor, op_and, op_xor,
        op_sll, op_srl, op_sra,
        op_add, op_sub, op_slt, op_sltu,
        op_mul, op_mulh, op_mulhu,
        op_ld_b, op_ld_bu, op_ld_h, op_ld_hu, op_ld_w, op_ll_w,
        op_st_b, op_st_h, op_st_w, op_sc_w,
        op_nop
    } aluop_t;

    // ############################################################
    // Instruction word, seen in its two immediate formats
    // ############################################################
    typedef struct packed {
        logic [9:0]  opcode;
        logic [11:0] si12;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } inst_2ri12_t;

    typedef struct packed {
        logic [7:0]  opcode;
        logic [13:0] si14;   // Word offset, scaled by four.
        logic [4:0]  rj;
        logic [4:0]  rd;
    } inst_2ri14_t;

    typedef union packed {
        inst_2ri12_t ri12;
        inst_2ri14_t ri14;
    } inst_word_u;

    typedef struct packed {
        aluop_t            aluop;
        logic [data_w-1:0] reg1;
        logic [data_w-1:0] reg2;
        inst_word_u        inst;
        logic              reg_write_en;
        logic [4:0]        reg_write_addr;
    } ex_issue_t;

    typedef struct packed {
        logic              valid;
        logic              op;      // 0 load, 1 store.
        logic [data_w-1:0] addr;
        logic [data_w-1:0] wdata;
        logic [strb_w-1:0] wstrb;
    } mem_req_t;

    typedef struct packed {
        logic                valid;
        aluop_t              aluop;
        logic                reg_write_en;
        logic [4:0]          reg_write_addr;
        logic [data_w-1:0]   reg_write_data;
        logic [data_w-1:0]   mem_addr;
        logic [ld_kinds-1:0] ld_en;
        logic [st_kinds-1:0] st_en;
        logic                ale;
    } ex_result_t;

    function automatic logic is_mem_op(aluop_t op);
        return op inside {op_ld_b, op_ld_bu, op_ld_h, op_ld_hu, op_ld_w, op_ll_w,
                          op_st_b, op_st_h, op_st_w, op_sc_w};
    endfunction

endpackage

//--- rtl/ex_alu.sv
`timescale 1ns/1ps

module ex_alu (
    input  ex_pkg::ex_issue_t          issue,
    output logic [ex_pkg::data_w-1:0]  result
);
    import ex_pkg::*;

    logic [data_w-1:0]   a;
    logic [data_w-1:0]   b;
    logic [4:0]          shamt;

    logic [data_w-1:0]   logic_res;
    logic [data_w-1:0]   shift_res;
    logic [data_w-1:0]   fill_mask;

    logic                subtract;
    logic [data_w-1:0]   b_mux;
    logic [data_w-1:0]   sum;
    logic                carry;
    logic                lt_signed;
    logic                lt_unsigned;

    logic                signed_mul;
    logic [data_w-1:0]   mag_a;
    logic [data_w-1:0]   mag_b;
    logic [2*data_w-1:0] mag_prod;
    logic [2*data_w-1:0] product;

    assign a     = issue.reg1;
    assign b     = issue.reg2;
    assign shamt = b[4:0];

    // ############################################################
    // Logic and shift
    // ############################################################
    always_comb begin
        case (issue.aluop)
            op_or:   logic_res = a | b;
            op_nor:  logic_res = ~(a | b);
            op_and:  logic_res = a & b;
            default: logic_res = a ^ b;
        endcase
    end

    // Top shamt bits set, to be filled with the sign on sra.
    assign fill_mask = ~({data_w{1'b1}} >> shamt);

    always_comb begin
        case (issue.aluop)
            op_sll:  shift_res = a << shamt;
            op_srl:  shift_res = a >> shamt;
            default: shift_res = (a >> shamt) | (fill_mask & {data_w{a[data_w-1]}});
        endcase
    end

    // ############################################################
    // Adder and comparator
    // ############################################################
    assign subtract = issue.aluop inside {op_sub, op_slt, op_sltu};
    assign b_mux    = subtract ? ~b : b;
    assign {carry, sum} = {1'b0, a} + {1'b0, b_mux} + {{data_w{1'b0}}, subtract};

    // Signs differ: the negative one is smaller. Otherwise the difference tells.
    assign lt_signed   = (a[data_w-1] != b[data_w-1]) ? a[data_w-1] : sum[data_w-1];
    assign lt_unsigned = ~carry;   // No carry out of a - b means a borrow.

    // ############################################################
    // Multiplier
    // ############################################################
    assign signed_mul = issue.aluop inside {op_mul, op_mulh};
    assign mag_a      = (signed_mul && a[data_w-1]) ? (~a + 1'b1) : a;
    assign mag_b      = (signed_mul && b[data_w-1]) ? (~b + 1'b1) : b;
    assign mag_prod   = {{data_w{1'b0}}, mag_a} * {{data_w{1'b0}}, mag_b};
    assign product    = (signed_mul && (a[data_w-1] ^ b[data_w-1])) ?
                        (~mag_prod + 1'b1) : mag_prod;

    always_comb begin
        case (issue.aluop)
            op_or, op_nor, op_and, op_xor: result = logic_res;
            op_sll, op_srl, op_sra:        result = shift_res;
            op_add, op_sub:                result = sum;
            op_slt:                        result = {{(data_w-1){1'b0}}, lt_signed};
            op_sltu:                       result = {{(data_w-1){1'b0}}, lt_unsigned};
            op_mul:                        result = product[data_w-1:0];
            op_mulh, op_mulhu:             result = product[2*data_w-1:data_w];
            default:                       result = '0;   // Memory ops and nop.
        endcase
    end

endmodule

//--- rtl/ex_lsu.sv
`timescale 1ns/1ps

module ex_lsu (
    input  logic                         clk,
    input  logic                         rst_n,
    input  ex_pkg::ex_issue_t            issue,
    input  logic                         in_valid,
    input  logic                         addr_ok,
    input  logic                         accept,
    output ex_pkg::mem_req_t             mem_req,
    output logic [ex_pkg::data_w-1:0]    mem_addr,
    output logic [ex_pkg::ld_kinds-1:0]  ld_en,
    output logic [ex_pkg::st_kinds-1:0]  st_en,
    output logic                         ale,
    output logic                         sc_ok,
    output logic                         mem_stall
);
    import ex_pkg::*;

    logic              ll_bit;
    logic              is_ll;
    logic              is_sc;
    logic              is_half;
    logic              is_word;
    logic              is_store;
    logic              req_valid;
    logic [11:0]       si12;
    logic [13:0]       si14;
    logic [data_w-1:0] st_data;
    logic [strb_w-1:0] st_strb;

    assign si12 = issue.inst.ri12.si12;
    assign si14 = issue.inst.ri14.si14;

    assign is_ll    = issue.aluop == op_ll_w;
    assign is_sc    = issue.aluop == op_sc_w;
    assign is_half  = issue.aluop inside {op_ld_h, op_ld_hu, op_st_h};
    assign is_word  = issue.aluop inside {op_ld_w, op_ll_w, op_st_w, op_sc_w};
    assign is_store = issue.aluop inside {op_st_b, op_st_h, op_st_w, op_sc_w};

    // ############################################################
    // Address generation
    // ############################################################
    always_comb begin
        case (issue.aluop)
            op_ld_b, op_ld_bu, op_ld_h, op_ld_hu, op_ld_w, op_ll_w: begin
                mem_addr = issue.reg1 + issue.reg2;
            end
            op_st_b, op_st_h, op_st_w: begin
                mem_addr = issue.reg1 + {{(data_w-12){si12[11]}}, si12};
            end
            op_sc_w: begin
                mem_addr = issue.reg1 + {{(data_w-16){si14[13]}}, si14, 2'b00};
            end
            default: begin
                mem_addr = '0;
            end
        endcase
    end

    assign ale = (is_half && mem_addr[0]) || (is_word && (mem_addr[1:0] != 2'b00));

    assign ld_en = {is_ll, issue.aluop == op_ld_w, issue.aluop == op_ld_hu,
                    issue.aluop == op_ld_h, issue.aluop == op_ld_bu, issue.aluop == op_ld_b};
    assign st_en = {is_sc && ll_bit, issue.aluop == op_st_w, issue.aluop == op_st_h,
                    issue.aluop == op_st_b};

    // Store lanes follow the low address bits.
    always_comb begin
        case (issue.aluop)
            op_st_b: begin
                st_strb = 4'b0001 << mem_addr[1:0];
                st_data = {4{issue.reg2[7:0]}};
            end
            op_st_h: begin
                st_strb = mem_addr[1] ? 4'b1100 : 4'b0011;
                st_data = {2{issue.reg2[15:0]}};
            end
            op_st_w, op_sc_w: begin
                st_strb = 4'b1111;
                st_data = issue.reg2;
            end
            default: begin
                st_strb = 4'b0000;
                st_data = '0;
            end
        endcase
    end

    // ############################################################
    // Request, stall and load-linked bit
    // ############################################################
    assign sc_ok     = is_sc && ll_bit && !ale;
    assign req_valid = in_valid && is_mem_op(issue.aluop) && !ale && !(is_sc && !ll_bit);
    assign mem_stall = req_valid && !addr_ok;

    assign mem_req = '{valid: req_valid, op: is_store, addr: mem_addr,
                       wdata: st_data, wstrb: st_strb};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ll_bit <= 1'b0;
        end else if (accept && is_ll && !ale) begin
            ll_bit <= 1'b1;
        end else if (accept && sc_ok) begin
            ll_bit <= 1'b0;   // A successful sc.w consumes the reservation.
        end
    end

endmodule

//--- rtl/ex_stage.sv
`timescale 1ns/1ps

module ex_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  ex_pkg::ex_issue_t  issue,
    input  logic               in_valid,
    input  logic               addr_ok,
    output logic               pause,
    output ex_pkg::mem_req_t   mem_req,
    output ex_pkg::ex_result_t ex_out
);
    import ex_pkg::*;

    logic [data_w-1:0]   alu_res;
    logic [data_w-1:0]   mem_addr;
    logic [ld_kinds-1:0] ld_en;
    logic [st_kinds-1:0] st_en;
    logic                ale;
    logic                sc_ok;
    logic                mem_stall;
    logic                accept;
    logic [data_w-1:0]   wb_data;

    ex_alu u_alu (
        .issue  (issue),
        .result (alu_res)
    );

    ex_lsu u_lsu (
        .clk       (clk),
        .rst_n     (rst_n),
        .issue     (issue),
        .in_valid  (in_valid),
        .addr_ok   (addr_ok),
        .accept    (accept),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .ld_en     (ld_en),
        .st_en     (st_en),
        .ale       (ale),
        .sc_ok     (sc_ok),
        .mem_stall (mem_stall)
    );

    assign pause  = mem_stall;
    assign accept = in_valid && !pause;

    // sc.w writes back its success flag; other memory ops write nothing here.
    always_comb begin
        if (issue.aluop == op_sc_w) begin
            wb_data = {{(data_w-1){1'b0}}, sc_ok};
        end else if (is_mem_op(issue.aluop)) begin
            wb_data = '0;
        end else begin
            wb_data = alu_res;
        end
    end

    // ############################################################
    // Output register
    // ############################################################
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_out.valid <= 1'b0;
        end else begin
            ex_out.valid <= accept;   // One cycle per accepted instruction.
        end
        if (accept) begin
            ex_out.aluop          <= issue.aluop;
            ex_out.reg_write_en   <= issue.reg_write_en;
            ex_out.reg_write_addr <= issue.reg_write_addr;
            ex_out.reg_write_data <= wb_data;
            ex_out.mem_addr       <= mem_addr;
            ex_out.ld_en          <= ld_en;
            ex_out.st_en          <= st_en;
            ex_out.ale            <= ale;
        end
    end

endmodule

//--- verification/ex_stage_sva.sv
`timescale 1ns/1ps

module ex_stage_sva (
    input logic               clk,
    input logic               rst_n,
    input ex_pkg::ex_issue_t  issue,
    input logic               in_valid,
    input logic               pause,
    input ex_pkg::mem_req_t   mem_req,
    input ex_pkg::ex_result_t ex_out
);

    a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !pause && !mem_req.valid)
        else $error("pause or mem_req.valid high in reset");

    a_reset_out: assert property (@(posedge clk) !rst_n |=> !ex_out.valid)
        else $error("ex_out.valid high after a reset cycle");

    // Byte, half or word lanes only.
    a_wstrb_legal: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_req.valid && mem_req.op) |->
            (mem_req.wstrb inside {4'h1, 4'h2, 4'h4, 4'h8, 4'h3, 4'hC, 4'hF}))
        else $error("illegal store strobe pattern");

    a_issue_held: assert property (@(posedge clk) disable iff (!rst_n)
        pause |=> $stable(issue) && in_valid)
        else $error("issue changed while the stage was paused");

    a_no_out_after_pause: assert property (@(posedge clk) disable iff (!rst_n)
        pause |=> !ex_out.valid)
        else $error("ex_out.valid followed a paused cycle");

endmodule

bind ex_stage ex_stage_sva u_sva (
    .clk      (clk),
    .rst_n    (rst_n),
    .issue    (issue),
    .in_valid (in_valid),
    .pause    (pause),
    .mem_req  (mem_req),
    .ex_out   (ex_out)
);

//--- verification/ex_checker.sv
`timescale 1ns/1ps

module ex_checker (
    input logic               clk,
    input logic               rst_n,
    input logic               addr_ok,
    input ex_pkg::mem_req_t   mem_req,
    input ex_pkg::ex_result_t ex_out
);
    import ex_pkg::*;

    typedef struct packed {
        aluop_t      op;
        logic        we;
        logic [4:0]  rd;
        logic [31:0] data;
        logic [31:0] addr;
        logic [5:0]  ld;
        logic [3:0]  st;
        logic        ale;
    } res_exp_t;

    typedef struct packed {
        logic        op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  strb;
    } req_exp_t;

    res_exp_t res_q[$];
    req_exp_t req_q[$];
    int       errors = 0;

    task automatic push_result(aluop_t op, logic we, logic [4:0] rd, logic [31:0] data,
                               logic [31:0] addr, logic [5:0] ld, logic [3:0] st,
                               logic ale);
        res_q.push_back('{op, we, rd, data, addr, ld, st, ale});
    endtask

    task automatic push_request(logic op, logic [31:0] addr, logic [31:0] wdata,
                                logic [3:0] strb);
        req_q.push_back('{op, addr, wdata, strb});
    endtask

    function automatic int pending();
        return res_q.size() + req_q.size();
    endfunction

    // The output register is steady at the falling edge.
    always @(negedge clk) begin
        res_exp_t got;
        res_exp_t exp;
        if (rst_n && ex_out.valid) begin
            got = '{ex_out.aluop, ex_out.reg_write_en, ex_out.reg_write_addr,
                    ex_out.reg_write_data, ex_out.mem_addr, ex_out.ld_en, ex_out.st_en,
                    ex_out.ale};
            if (res_q.size() == 0) begin
                $display("An ex_out.valid came with no instruction outstanding at %0t.", $time);
                errors++;
            end else begin
                exp = res_q.pop_front();
                if (got != exp) begin
                    $display("[ERROR] %0t: ex_out got %h, expected %h", $time, got, exp);
                    errors++;
                end
            end
        end
    end

    always @(negedge clk) begin
        req_exp_t got;
        #1;
        if (rst_n && mem_req.valid && addr_ok) begin
            got = '{mem_req.op, mem_req.addr, mem_req.wdata, mem_req.wstrb};
            if (req_q.size() == 0) begin
                $display("A memory request was taken that no instruction asked for at %0t.",
                         $time);
                errors++;
            end else if (got != req_q[0]) begin
                $display("[ERROR] %0t: mem_req got %h, expected %h", $time, got, req_q[0]);
                errors++;
                void'(req_q.pop_front());
            end else begin
                void'(req_q.pop_front());
            end
        end
    end

endmodule

//--- verification/tb_ex_stage.sv
`timescale 1ns/1ps

module tb_ex_stage;
    import ex_pkg::*;

    typedef struct packed {
        aluop_t      op;
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] inst;
        logic [31:0] data;    // Expected reg_write_data.
        logic [31:0] addr;    // Expected ex_out.mem_addr and request address.
        logic [5:0]  ld;
        logic [3:0]  strb;
        logic [31:0] wdata;
        logic        ale;
        logic        req;     // A memory request is expected.
    } row_t;

    localparam int n_rows      = 32;
    localparam int wait_cycles = 50;

    logic       clk;
    logic       rst_n;
    logic       in_valid;
    logic       addr_ok;
    logic       pause;
    ex_issue_t  issue;
    mem_req_t   mem_req;
    ex_result_t ex_out;
    row_t       rows [n_rows];
    int         timeouts = 0;

    ex_stage dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .issue    (issue),
        .in_valid (in_valid),
        .addr_ok  (addr_ok),
        .pause    (pause),
        .mem_req  (mem_req),
        .ex_out   (ex_out)
    );

    ex_checker chk (
        .clk     (clk),
        .rst_n   (rst_n),
        .addr_ok (addr_ok),
        .mem_req (mem_req),
        .ex_out  (ex_out)
    );

    function automatic logic [31:0] imm12(logic [11:0] si);
        return {10'b0, si, 10'b0};
    endfunction

    function automatic logic [31:0] imm14(logic [13:0] si);
        return {8'b0, si, 10'b0};
    endfunction

    // One-hot store kind; sc.w counts only while it holds the reservation.
    function automatic logic [3:0] store_kind(aluop_t op, logic sc_pass);
        case (op)
            op_st_b: return 4'b0001;
            op_st_h: return 4'b0010;
            op_st_w: return 4'b0100;
            op_sc_w: return {sc_pass, 3'b000};
            default: return 4'b0000;
        endcase
    endfunction

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Memory side refuses about one cycle in three.
    initial begin
        void'($urandom(32'h4a87_179a));
        forever begin
            @(negedge clk);
            addr_ok <= ($urandom % 3) != 0;
        end
    end

    // ############################################################
    // Stimulus and expected values
    // ############################################################
    initial begin
        int waited;
        rst_n = 1'b0;
        in_valid = 1'b0;
        addr_ok = 1'b0;
        issue = '0;
        rows = '{
            '{op_or,  32'hF0F00000, 32'h0FF000FF, '0, 32'hFFF000FF, '0, 6'h00, 4'h0, '0, 1'b0, 1'b0},
            '{op_nor, 32'hF0F00000, 32'h0FF000FF, '0, 32'h000FFF00, '0, 6'h00, 4'h0, '0, 1'b0, 1'b0},
            '{op_and, 32'hF0F00000, 32'h0FF000FF, '0, 32'h00F00000, '0, 6'h00, 4'h0, '0, 1'b0, 1'b0},
            '{op_xor, 32'hF0F00000, 32'h0FF000FF, '0, 32'hFF0000FF, '0, 6'h00, 4'h0, '0, 1'b0, 1'b0},
            '{op_sll, 32'h80000001, 32'd4, '0, 32'h00000010, '0, 6'h00, 4'h0, '0, 1'b0, 1'b0},
            '{op_srl, 32'h80000001, 32'd4, '0, 32'h08000000, '0, 6'h00, 4'h0, '0, 1'b0, 1'b0},
            '{op_sra, 32'h80000010, 32'd0, '0, 32'h80000010, '0, 6'h00, 4'h0, '0, 1'b0, 1'b0},
            '{op_sra, 32'h80000010, 32'd31, '0, 32'hFFFFFFFF, '0, 6'h00, 4'h0, '0, 1'b0, 1'b0},
            '{op_add, 32'h7FFFFFFF, 32'd1, '0, 32'h80000000, '0, 6'h00, 4'h0, '0, 1'b0, 1'b0},
            '{op_sub, 32'h80000000, 32'd1, '0, 32'h7FFFFFFF, '0, 6'h00, 4'h0, '0, 1'b0, 1'b0},
            '{op_slt, 32'hFFFFFFFF, 32'd1, '0, 32'd1, '0, 6'h00, 4'h0, '0, 1'b0, 1'b0},
            '{op_slt, 32'h7FFFFFFF, 32'h80000000, '0, 32'd0, '0, 6'h00, 4'h0, '0, 1'b0, 1'b0},
            '{op_sltu, 32'd1, 32'hFFFFFFFF, '0, 32'd1, '0, 6'h00, 4'h0, '0, 1'b0, 1'b0},
            '{op_mul, 32'hFFFFFFFD, 32'hFFFFFFFB, '0, 32'h0000000F, '0, 6'h00, 4'h0, '0, 1'b0, 1'b0},
            '{op_mulh, 32'hFFFFFFFD, 32'hFFFFFFFB, '0, 32'h0, '0, 6'h00, 4'h0, '0, 1'b0, 1'b0},
            '{op_mulh, 32'hFFFFFFFE, 32'd3, '0, 32'hFFFFFFFF, '0, 6'h00, 4'h0, '0, 1'b0, 1'b0},
            '{op_mul, 32'hFFFFFFFE, 32'd3, '0, 32'hFFFFFFFA, '0, 6'h00, 4'h0, '0, 1'b0, 1'b0},
            '{op_mulhu, 32'hFFFFFFFF, 32'hFFFFFFFF, '0, 32'hFFFFFFFE, '0, 6'h00, 4'h0, '0,
              1'b0, 1'b0},
            '{op_st_b, 32'h1000, 32'h112233AB, imm12(12'h003), '0, 32'h1003, 6'h00, 4'h8,
              32'hABABABAB, 1'b0, 1'b1},
            '{op_st_h, 32'h2000, 32'h55667788, imm12(12'h002), '0, 32'h2002, 6'h00, 4'hC,
              32'h77887788, 1'b0, 1'b1},
            '{op_st_h, 32'h2000, 32'h55667788, imm12(12'h001), '0, 32'h2001, 6'h00, 4'h0, '0,
              1'b1, 1'b0},
            '{op_st_w, 32'h3000, 32'hDEADBEEF, imm12(12'hFFC), '0, 32'h2FFC, 6'h00, 4'hF,
              32'hDEADBEEF, 1'b0, 1'b1},
            '{op_st_w, 32'h3000, 32'hDEADBEEF, imm12(12'h002), '0, 32'h3002, 6'h00, 4'h0, '0,
              1'b1, 1'b0},
            '{op_ld_b, 32'h4000, 32'd3, '0, '0, 32'h4003, 6'h01, 4'h0, '0, 1'b0, 1'b1},
            '{op_ld_h, 32'h4000, 32'd2, '0, '0, 32'h4002, 6'h04, 4'h0, '0, 1'b0, 1'b1},
            '{op_ld_hu, 32'h4000, 32'd3, '0, '0, 32'h4003, 6'h08, 4'h0, '0, 1'b1, 1'b0},
            '{op_ld_w, 32'h4000, 32'd4, '0, '0, 32'h4004, 6'h10, 4'h0, '0, 1'b0, 1'b1},
            '{op_sc_w, 32'h5000, 32'h12345678, imm14(14'h0002), 32'd0, 32'h5008, 6'h00, 4'h0,
              '0, 1'b0, 1'b0},
            '{op_ll_w, 32'h5000, 32'd8, '0, '0, 32'h5008, 6'h20, 4'h0, '0, 1'b0, 1'b1},
            '{op_sc_w, 32'h5000, 32'h12345678, imm14(14'h0002), 32'd1, 32'h5008, 6'h00, 4'hF,
              32'h12345678, 1'b0, 1'b1},
            '{op_sc_w, 32'h5000, 32'h12345678, imm14(14'h0002), 32'd0, 32'h5008, 6'h00, 4'h0,
              '0, 1'b0, 1'b0},
            '{op_ld_bu, 32'h4000, 32'd1, '0, '0, 32'h4001, 6'h02, 4'h0, '0, 1'b0, 1'b1}
        };
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < n_rows; i++) begin
            issue = '{aluop: rows[i].op, reg1: rows[i].r1, reg2: rows[i].r2,
                      inst: rows[i].inst, reg_write_en: i[0], reg_write_addr: i[4:0]};
            in_valid = 1'b1;
            chk.push_result(rows[i].op, i[0], i[4:0], rows[i].data, rows[i].addr, rows[i].ld,
                            store_kind(rows[i].op, rows[i].data[0]), rows[i].ale);
            if (rows[i].req) begin
                chk.push_request(rows[i].strb != 4'h0, rows[i].addr, rows[i].wdata,
                                 rows[i].strb);
            end
            waited = 0;
            #1;
            while (pause && waited < wait_cycles) begin
                @(negedge clk);
                #1;
                waited++;
            end
            if (pause) begin
                $display("Row %0d was never accepted: pause stayed high.", i);
                timeouts++;
                break;
            end
            @(negedge clk);
        end
        in_valid = 1'b0;
        issue.aluop = op_nop;

        waited = 0;
        while (chk.pending() != 0 && waited < wait_cycles) begin
            @(negedge clk);
            waited++;
        end
        if (chk.pending() != 0) begin
            $display("Outputs still missing for %0d expectations at the end.", chk.pending());
            timeouts++;
        end

        $display("errors: %0d, timeouts: %0d", chk.errors, timeouts);
        if (chk.errors == 0 && timeouts == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- all.f
rtl/ex_pkg.sv
rtl/ex_alu.sv
rtl/ex_lsu.sv
rtl/ex_stage.sv
verification/ex_stage_sva.sv
verification/ex_checker.sv
verification/tb_ex_stage.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_ex_stage
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
